// ==== hdl/vstu_pkg.sv ====
// Vector store unit package
// Sizing constants and the types shared by the store unit blocks,
// covering lane operands, W beats, instruction IDs and queue requests

package vstu_pkg;

  ////////////////////////////////////////
  // Sizing
  ////////////////////////////////////////

  // Lanes in the vector register file
  localparam int unsigned NrLanes = 4;
  // Bytes per lane operand
  localparam int unsigned ElenBytes = 8;
  // One whole register file word per W beat
  localparam int unsigned BeatBytes = NrLanes * ElenBytes;
  // Store instruction queue entries
  localparam int unsigned QueueDepth = 4;
  // Instruction IDs tracked by the sequencer
  localparam int unsigned NrVInsn = 8;

  // Field widths
  localparam int unsigned VlWidth = 8;
  localparam int unsigned ByteCntWidth = 11;
  localparam int unsigned BurstLenWidth = 8;
  localparam int unsigned QPtrWidth = $clog2(QueueDepth);

  ////////////////////////////////////////
  // Data types
  ////////////////////////////////////////

  typedef logic [ElenBytes*8-1:0] elen_t;
  typedef logic [BeatBytes*8-1:0] beat_data_t;
  typedef logic [BeatBytes-1:0] beat_strb_t;

  ////////////////////////////////////////
  // Control types
  ////////////////////////////////////////

  typedef logic [$clog2(NrVInsn)-1:0] insn_id_t;
  typedef logic [VlWidth-1:0] vl_t;
  // 0 to 3 selects 1, 2, 4 or 8 byte elements
  typedef logic [1:0] vsew_t;
  // Large enough for vl shifted by the widest vsew
  typedef logic [ByteCntWidth-1:0] byte_cnt_t;
  // AXI style length, beats minus one
  typedef logic [BurstLenWidth-1:0] burst_len_t;
  typedef logic [NrVInsn-1:0] insn_mask_t;

  // Queue pointers and occupancy counters
  typedef logic [QPtrWidth-1:0] q_ptr_t;
  typedef logic [QPtrWidth:0] q_cnt_t;

  // Store request from the sequencer
  typedef struct packed {
    insn_id_t id;
    vl_t      vl;
    vsew_t    vsew;
  } store_req_t;

endpackage

// ==== hdl/store_issue_if.sv ====
// Issue phase link between the instruction queue and the W-beat packer
// The queue presents the instruction at the head of the issue phase,
// the packer pulses done when that instruction's last beat goes out

`timescale 1ns/1ps

interface store_issue_if import vstu_pkg::*; ();

  // Head of the issue phase is valid
  logic  issue_valid;
  // Vector length and element width of that instruction
  vl_t   issue_vl;
  vsew_t issue_vsew;
  // Last beat of the instruction transferred
  logic  issue_done;

  // Queue side
  modport queue_mp (
    output issue_valid,
    output issue_vl,
    output issue_vsew,
    input  issue_done
  );

  // Packer side
  modport packer_mp (
    input  issue_valid,
    input  issue_vl,
    input  issue_vsew,
    output issue_done
  );

endinterface

// ==== hdl/lane_spill_reg.sv ====
// One-entry fall-through register
// Passes data straight through while empty and the consumer is ready,
// otherwise parks one item and drops ready until that item drains

`timescale 1ns/1ps

module lane_spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  output T     data_o,
  output logic valid_o,
  input  logic ready_i
);

  // Occupancy flag and the parked item
  logic full_q;
  T     data_q;

  // Only accept new data while nothing is parked
  assign ready_o = !full_q;

  // Parked item has priority over the input
  assign valid_o = full_q | valid_i;
  assign data_o  = full_q ? data_q : data_i;

  // Occupancy follows the consumer handshake
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      // Drains once the consumer takes it
      if (ready_i) full_q <= 1'b0;
    end else if (valid_i && !ready_i) begin
      full_q <= 1'b1;
    end
  end

  // Capture on a stalled pass-through
  always_ff @(posedge clk_i) begin
    if (!full_q && valid_i && !ready_i) begin
      data_q <= data_i;
    end
  end

endmodule

// ==== hdl/store_insn_queue.sv ====
// Store instruction queue
// Holds up to four store instructions over the accept, issue and
// commit phases, blocks requests whose ID is still running, and
// commits one issued store per B response with a done pulse

`timescale 1ns/1ps

module store_insn_queue import vstu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Sequencer request
  input  store_req_t             req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  insn_mask_t             vinsn_running_i,
  // Head of the issue phase
  store_issue_if.queue_mp        issue,
  // AXI B channel
  input  logic                   axi_b_valid_i,
  output logic                   axi_b_ready_o,
  // Status toward the sequencer
  output logic                   store_pending_o,
  output insn_mask_t             vinsn_done_o
);

  // Wrapping pointer increment
  function automatic q_ptr_t next_ptr(input q_ptr_t ptr);
    if (ptr == q_ptr_t'(QueueDepth - 1)) begin
      return '0;
    end
    return ptr + q_ptr_t'(1);
  endfunction

  ////////////////////////////////////////
  // State
  ////////////////////////////////////////

  // Stored requests
  store_req_t [QueueDepth-1:0] entries_q;

  // One pointer per execution phase
  q_ptr_t accept_pnt_q, accept_pnt_d;
  q_ptr_t issue_pnt_q, issue_pnt_d;
  q_ptr_t commit_pnt_q, commit_pnt_d;

  // Instructions waiting to be issued, and not yet committed
  q_cnt_t issue_cnt_q, issue_cnt_d;
  q_cnt_t commit_cnt_q, commit_cnt_d;

  // IDs taken by this unit and still running
  insn_mask_t running_q, running_d;
  insn_mask_t done_d;

  // Held high from the first cycle after reset
  logic b_ready_q;

  logic queue_full;
  logic req_fire;
  logic b_fire;
  logic commit_pending;

  ////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////

  // Commit counter covers every stored instruction
  assign queue_full      = (commit_cnt_q == q_cnt_t'(QueueDepth));
  assign store_pending_o = (commit_cnt_q != '0);

  // Room left and the ID is free
  assign req_ready_o = !queue_full && !running_q[req_i.id];
  assign req_fire    = req_valid_i && req_ready_o;

  // Every response is acknowledged
  assign axi_b_ready_o = b_ready_q;
  assign b_fire        = axi_b_valid_i && b_ready_q;

  // Something issued but not committed, the head finishing this cycle counts
  assign commit_pending = (commit_cnt_q != issue_cnt_q) || issue.issue_done;

  // Issue head
  assign issue.issue_valid = (issue_cnt_q != '0);
  assign issue.issue_vl    = entries_q[issue_pnt_q].vl;
  assign issue.issue_vsew  = entries_q[issue_pnt_q].vsew;

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    accept_pnt_d = accept_pnt_q;
    issue_pnt_d  = issue_pnt_q;
    commit_pnt_d = commit_pnt_q;
    issue_cnt_d  = issue_cnt_q;
    commit_cnt_d = commit_cnt_q;
    done_d       = '0;

    // Sequencer clears the IDs it has retired
    running_d = running_q & vinsn_running_i;

    // Head finished sending its beats
    if (issue.issue_done) begin
      issue_pnt_d = next_ptr(issue_pnt_q);
      issue_cnt_d = issue_cnt_q - q_cnt_t'(1);
    end

    // One store retired per B response
    if (b_fire && commit_pending) begin
      done_d[entries_q[commit_pnt_q].id] = 1'b1;
      commit_pnt_d = next_ptr(commit_pnt_q);
      commit_cnt_d = commit_cnt_q - q_cnt_t'(1);
    end

    // New store enters both phases
    if (req_fire) begin
      accept_pnt_d           = next_ptr(accept_pnt_q);
      issue_cnt_d            = issue_cnt_d + q_cnt_t'(1);
      commit_cnt_d           = commit_cnt_d + q_cnt_t'(1);
      running_d[req_i.id]    = 1'b1;
    end
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      running_q    <= '0;
      vinsn_done_o <= '0;
      b_ready_q    <= 1'b0;
    end else begin
      accept_pnt_q <= accept_pnt_d;
      issue_pnt_q  <= issue_pnt_d;
      commit_pnt_q <= commit_pnt_d;
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      running_q    <= running_d;
      // Done bits last a single cycle
      vinsn_done_o <= done_d;
      b_ready_q    <= 1'b1;
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      entries_q[accept_pnt_q] <= req_i;
    end
  end

endmodule

// ==== hdl/w_beat_packer.sv ====
// W-beat packer
// Joins one operand from every lane into a full-width W beat, strobes
// the bytes the instruction still owns, marks the end of each address
// generator burst and acknowledges that burst on its last beat

`timescale 1ns/1ps

module w_beat_packer import vstu_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Instruction at the head of the issue phase
  store_issue_if.packer_mp         issue,
  // Lane operands
  input  elen_t      [NrLanes-1:0] operand_i,
  input  logic       [NrLanes-1:0] operand_valid_i,
  output logic       [NrLanes-1:0] operand_ready_o,
  // Address generator burst
  input  logic                     addrgen_valid_i,
  input  burst_len_t               addrgen_len_i,
  output logic                     addrgen_ready_o,
  // AXI W channel
  output beat_data_t               axi_w_data_o,
  output beat_strb_t               axi_w_strb_o,
  output logic                     axi_w_last_o,
  output logic                     axi_w_valid_o,
  input  logic                     axi_w_ready_i
);

  ////////////////////////////////////////
  // Byte and beat counters
  ////////////////////////////////////////

  // Bytes left in the current instruction
  byte_cnt_t rem_q, rem_d;
  // Count not yet loaded for the head instruction
  logic      loaded_q, loaded_d;
  byte_cnt_t rem_cur;
  byte_cnt_t beat_bytes;

  // Beats already sent in the current burst
  burst_len_t beat_cnt_q, beat_cnt_d;

  logic w_fire;
  logic final_beat;

  // First cycle of an instruction takes vl times element bytes directly
  assign rem_cur = loaded_q ? rem_q
                            : byte_cnt_t'(byte_cnt_t'(issue.issue_vl) << issue.issue_vsew);

  // At most one register file word per beat
  assign beat_bytes = (rem_cur > byte_cnt_t'(BeatBytes)) ? byte_cnt_t'(BeatBytes) : rem_cur;
  assign final_beat = (rem_cur <= byte_cnt_t'(BeatBytes));

  ////////////////////////////////////////
  // W beat
  ////////////////////////////////////////

  // Needs the instruction, every lane and a burst, never waits on ready
  assign axi_w_valid_o = issue.issue_valid && (&operand_valid_i) && addrgen_valid_i;
  assign w_fire        = axi_w_valid_o && axi_w_ready_i;

  // Lane n lands on bytes 8n to 8n+7
  assign axi_w_data_o = operand_i;

  // Lowest bytes of the instruction's remainder
  always_comb begin
    axi_w_strb_o = '0;
    for (int b = 0; b < BeatBytes; b++) begin
      axi_w_strb_o[b] = (byte_cnt_t'(b) < beat_bytes);
    end
  end

  // Burst completes on its len+1-th beat
  assign axi_w_last_o    = (beat_cnt_q == addrgen_len_i);
  assign addrgen_ready_o = w_fire && axi_w_last_o;

  // All lanes consumed together with the beat
  assign operand_ready_o = {NrLanes{w_fire}};

  // Head instruction fully sent
  assign issue.issue_done = w_fire && final_beat;

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    rem_d      = rem_q;
    loaded_d   = loaded_q;
    beat_cnt_d = beat_cnt_q;

    // Latch the byte count once the head shows up
    if (issue.issue_valid && !loaded_q) begin
      rem_d    = rem_cur;
      loaded_d = 1'b1;
    end

    if (w_fire) begin
      // Restart on the next burst
      beat_cnt_d = axi_w_last_o ? '0 : beat_cnt_q + burst_len_t'(1);
      if (final_beat) begin
        // Next head reloads from its own vl
        rem_d    = '0;
        loaded_d = 1'b0;
      end else begin
        rem_d    = rem_cur - byte_cnt_t'(BeatBytes);
        loaded_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rem_q      <= '0;
      loaded_q   <= 1'b0;
      beat_cnt_q <= '0;
    end else begin
      rem_q      <= rem_d;
      loaded_q   <= loaded_d;
      beat_cnt_q <= beat_cnt_d;
    end
  end

endmodule

// ==== hdl/vstu_top.sv ====
// Vector store unit top level
// Lane operand and request registers in front of the instruction
// queue and the W-beat packer, with plain ports toward the sequencer,
// the lanes, the address generator and the AXI W and B channels

`timescale 1ns/1ps

module vstu_top import vstu_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Sequencer
  input  logic                     pe_req_valid_i,
  input  insn_id_t                 pe_req_id_i,
  input  vl_t                      pe_req_vl_i,
  input  vsew_t                    pe_req_vsew_i,
  output logic                     pe_req_ready_o,
  input  insn_mask_t               pe_vinsn_running_i,
  // Lanes
  input  elen_t      [NrLanes-1:0] operand_i,
  input  logic       [NrLanes-1:0] operand_valid_i,
  output logic       [NrLanes-1:0] operand_ready_o,
  // Address generator
  input  logic                     addrgen_valid_i,
  input  burst_len_t               addrgen_len_i,
  output logic                     addrgen_ready_o,
  // AXI W
  output beat_data_t               axi_w_data_o,
  output beat_strb_t               axi_w_strb_o,
  output logic                     axi_w_last_o,
  output logic                     axi_w_valid_o,
  input  logic                     axi_w_ready_i,
  // AXI B
  input  logic                     axi_b_valid_i,
  output logic                     axi_b_ready_o,
  // Status
  output logic                     store_pending_o,
  output insn_mask_t               vinsn_done_o
);

  ////////////////////////////////////////
  // Input registers
  ////////////////////////////////////////

  // Request fields gathered into one struct
  store_req_t pe_req_in;
  store_req_t pe_req;
  logic       pe_req_valid;
  logic       pe_req_ready;

  assign pe_req_in = '{id: pe_req_id_i, vl: pe_req_vl_i, vsew: pe_req_vsew_i};

  lane_spill_reg #(
    .T(store_req_t)
  ) u_req_reg (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (pe_req_in),
    .valid_i(pe_req_valid_i),
    .ready_o(pe_req_ready_o),
    .data_o (pe_req),
    .valid_o(pe_req_valid),
    .ready_i(pe_req_ready)
  );

  // Packer side of the lane registers
  elen_t [NrLanes-1:0] lane_operand;
  logic  [NrLanes-1:0] lane_valid;
  logic  [NrLanes-1:0] lane_ready;

  for (genvar lane = 0; lane < NrLanes; lane++) begin : gen_lane_regs
    lane_spill_reg #(
      .T(elen_t)
    ) u_lane_reg (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .data_i (operand_i[lane]),
      .valid_i(operand_valid_i[lane]),
      .ready_o(operand_ready_o[lane]),
      .data_o (lane_operand[lane]),
      .valid_o(lane_valid[lane]),
      .ready_i(lane_ready[lane])
    );
  end

  ////////////////////////////////////////
  // Queue and packer
  ////////////////////////////////////////

  store_issue_if issue_if ();

  store_insn_queue u_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (pe_req),
    .req_valid_i    (pe_req_valid),
    .req_ready_o    (pe_req_ready),
    .vinsn_running_i(pe_vinsn_running_i),
    .issue          (issue_if.queue_mp),
    .axi_b_valid_i  (axi_b_valid_i),
    .axi_b_ready_o  (axi_b_ready_o),
    .store_pending_o(store_pending_o),
    .vinsn_done_o   (vinsn_done_o)
  );

  w_beat_packer u_packer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue          (issue_if.packer_mp),
    .operand_i      (lane_operand),
    .operand_valid_i(lane_valid),
    .operand_ready_o(lane_ready),
    .addrgen_valid_i(addrgen_valid_i),
    .addrgen_len_i  (addrgen_len_i),
    .addrgen_ready_o(addrgen_ready_o),
    .axi_w_data_o   (axi_w_data_o),
    .axi_w_strb_o   (axi_w_strb_o),
    .axi_w_last_o   (axi_w_last_o),
    .axi_w_valid_o  (axi_w_valid_o),
    .axi_w_ready_i  (axi_w_ready_i)
  );

endmodule

// ==== testbench/vstu_asserts.sv ====
// Handshake assertions for the vector store unit
// W payload and valid hold through stalls and done bits are one-hot

`timescale 1ns/1ps

module vstu_asserts import vstu_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       axi_w_valid_o,
  input logic       axi_w_ready_i,
  input logic       axi_w_last_o,
  input beat_data_t axi_w_data_o,
  input beat_strb_t axi_w_strb_o,
  input insn_mask_t vinsn_done_o
);

  // Number of failed assertions
  int unsigned fail_count = 0;

  // Stalled beat keeps its payload
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_w_valid_o && !axi_w_ready_i |=>
      $stable(axi_w_data_o) && $stable(axi_w_strb_o) && $stable(axi_w_last_o))
    else begin
      fail_count++;
      $error("W payload changed while stalled");
    end

  // Valid stays up until the beat is taken
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_w_valid_o && !axi_w_ready_i |=> axi_w_valid_o)
    else begin
      fail_count++;
      $error("W valid dropped before ready");
    end

  // At most one store retires per cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(vinsn_done_o))
    else begin
      fail_count++;
      $error("More than one done bit set");
    end

endmodule

// ==== testbench/vstu_checker.sv ====
// Vector store unit checker
// Tracks accepted lane operands, predicts each W beat, its strobe and
// last flag, and the done bit that follows every B handshake

`timescale 1ns/1ps

module vstu_checker import vstu_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  elen_t [NrLanes-1:0] operand_i,
  input  logic  [NrLanes-1:0] operand_valid_i,
  input  logic  [NrLanes-1:0] operand_ready_o,
  input  logic                addrgen_ready_o,
  input  beat_data_t          axi_w_data_o,
  input  beat_strb_t          axi_w_strb_o,
  input  logic                axi_w_last_o,
  input  logic                axi_w_valid_o,
  input  logic                axi_w_ready_i,
  input  logic                axi_b_valid_i,
  input  logic                axi_b_ready_o,
  input  insn_mask_t          vinsn_done_o,
  output int unsigned         error_count_o,
  output int unsigned         beat_count_o,
  output int unsigned         done_count_o
);

  // Operands accepted per lane in order
  elen_t       lane_q [NrLanes][$];
  // Expected instructions in acceptance order
  insn_id_t    exp_id_q[$];
  int unsigned exp_beats_q[$];
  int unsigned exp_last_q[$];
  int unsigned exp_len_q[$];
  // Fully sent and waiting for a B response
  insn_id_t    commit_q[$];

  int unsigned errors = 0;
  int unsigned beats = 0;
  int unsigned dones = 0;
  int unsigned beat_idx = 0;
  int unsigned burst_idx = 0;
  insn_mask_t  done_exp = '0;

  assign error_count_o = errors;
  assign beat_count_o  = beats;
  assign done_count_o  = dones;

  function automatic void add_expected(input insn_id_t id, input int unsigned n_beats,
                                       input int unsigned last_bytes, input int unsigned len);
    exp_id_q.push_back(id);
    exp_beats_q.push_back(n_beats);
    exp_last_q.push_back(last_bytes);
    exp_len_q.push_back(len);
  endfunction

  task automatic check_beat();
    beat_data_t  exp_data;
    beat_strb_t  exp_strb;
    logic        exp_last;
    int unsigned nbytes;
    exp_data = '0;
    beats++;
    for (int l = 0; l < NrLanes; l++) begin
      if (lane_q[l].size() == 0) begin
        errors++;
        $display("ERROR: W beat sent with no operand accepted on lane %0d", l);
      end else begin
        exp_data[l*ElenBytes*8 +: ElenBytes*8] = lane_q[l].pop_front();
      end
    end
    if (exp_id_q.size() == 0) begin
      errors++;
      $display("ERROR: W beat sent with no store instruction expected");
      return;
    end
    // Only the final beat of an instruction is partial
    nbytes = (beat_idx == exp_beats_q[0] - 1) ? exp_last_q[0] : BeatBytes;
    exp_strb = '0;
    for (int unsigned b = 0; b < BeatBytes; b++) exp_strb[b] = (b < nbytes);
    exp_last = (burst_idx == exp_len_q[0]);
    if (axi_w_data_o !== exp_data) begin
      errors++;
      $display("MISMATCH axi_w_data_o: expected %h, got %h", exp_data, axi_w_data_o);
    end
    if (axi_w_strb_o !== exp_strb) begin
      errors++;
      $display("MISMATCH axi_w_strb_o: expected %h, got %h", exp_strb, axi_w_strb_o);
    end
    if (axi_w_last_o !== exp_last) begin
      errors++;
      $display("MISMATCH axi_w_last_o: expected %h, got %h", exp_last, axi_w_last_o);
    end
    if (addrgen_ready_o !== exp_last) begin
      errors++;
      $display("MISMATCH addrgen_ready_o: expected %h, got %h", exp_last, addrgen_ready_o);
    end
    burst_idx = exp_last ? 0 : burst_idx + 1;
    beat_idx++;
    if (beat_idx == exp_beats_q[0]) begin
      commit_q.push_back(exp_id_q.pop_front());
      void'(exp_beats_q.pop_front());
      void'(exp_last_q.pop_front());
      void'(exp_len_q.pop_front());
      beat_idx  = 0;
      burst_idx = 0;
    end
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      // Done bit lands one cycle after its B handshake
      if (vinsn_done_o !== done_exp) begin
        errors++;
        $display("MISMATCH vinsn_done_o: expected %h, got %h", done_exp, vinsn_done_o);
      end
      if (vinsn_done_o != '0) dones++;
      for (int l = 0; l < NrLanes; l++) begin
        if (operand_valid_i[l] && operand_ready_o[l]) lane_q[l].push_back(operand_i[l]);
      end
      if (axi_w_valid_o && axi_w_ready_i) begin
        check_beat();
      end else if (addrgen_ready_o !== 1'b0) begin
        // Burst acknowledge only rides on a transferring beat
        errors++;
        $display("MISMATCH addrgen_ready_o: expected %h, got %h", 1'b0, addrgen_ready_o);
      end
      done_exp = '0;
      if (axi_b_valid_i && axi_b_ready_o && commit_q.size() != 0) begin
        done_exp = insn_mask_t'(1) << commit_q.pop_front();
      end
    end
  end

endmodule

// ==== testbench/tb_vstu.sv ====
// Vector store unit testbench
// Reads store instructions from the vector file, feeds requests,
// lane operands, address bursts and B responses, and stalls W at random

`timescale 1ns/1ps

module tb_vstu import vstu_pkg::*; ();

  // Upper bound for any single wait in cycles
  localparam int unsigned WaitLimit   = 20000;
  localparam int unsigned StallCycles = 20;

  logic                clk_i;
  logic                rst_ni;
  logic                pe_req_valid_i;
  insn_id_t            pe_req_id_i;
  vl_t                 pe_req_vl_i;
  vsew_t               pe_req_vsew_i;
  logic                pe_req_ready_o;
  insn_mask_t          pe_vinsn_running_i;
  elen_t [NrLanes-1:0] operand_i;
  logic  [NrLanes-1:0] operand_valid_i;
  logic  [NrLanes-1:0] operand_ready_o;
  logic                addrgen_valid_i;
  burst_len_t          addrgen_len_i;
  logic                addrgen_ready_o;
  beat_data_t          axi_w_data_o;
  beat_strb_t          axi_w_strb_o;
  logic                axi_w_last_o;
  logic                axi_w_valid_o;
  logic                axi_w_ready_i;
  logic                axi_b_valid_i;
  logic                axi_b_ready_o;
  logic                store_pending_o;
  insn_mask_t          vinsn_done_o;

  // Vector file contents
  insn_id_t    vec_id[$];
  vl_t         vec_vl[$];
  vsew_t       vec_vsew[$];
  burst_len_t  vec_len[$];
  int unsigned total_beats;

  logic [15:0] lfsr_q;
  int unsigned tb_errors;
  int unsigned timeouts;
  int unsigned issued_cnt;
  int unsigned b_sent;
  logic        b_hold;
  logic        finished;
  int unsigned checker_errors;
  int unsigned beat_count;
  int unsigned done_count;

  vstu_top UUT (.*);

  vstu_checker u_checker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .operand_i      (operand_i),
    .operand_valid_i(operand_valid_i),
    .operand_ready_o(operand_ready_o),
    .addrgen_ready_o(addrgen_ready_o),
    .axi_w_data_o   (axi_w_data_o),
    .axi_w_strb_o   (axi_w_strb_o),
    .axi_w_last_o   (axi_w_last_o),
    .axi_w_valid_o  (axi_w_valid_o),
    .axi_w_ready_i  (axi_w_ready_i),
    .axi_b_valid_i  (axi_b_valid_i),
    .axi_b_ready_o  (axi_b_ready_o),
    .vinsn_done_o   (vinsn_done_o),
    .error_count_o  (checker_errors),
    .beat_count_o   (beat_count),
    .done_count_o   (done_count)
  );

  bind vstu_top vstu_asserts u_asserts (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .axi_w_valid_o(axi_w_valid_o),
    .axi_w_ready_i(axi_w_ready_i),
    .axi_w_last_o (axi_w_last_o),
    .axi_w_data_o (axi_w_data_o),
    .axi_w_strb_o (axi_w_strb_o),
    .vinsn_done_o (vinsn_done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Random bits
  ////////////////////////////////////////

  // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic next_rand_bit();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) lfsr_q = lfsr_q ^ 16'hB400;
    return out;
  endfunction

  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[62:0], next_rand_bit()};
    end
    return v;
  endfunction

  ////////////////////////////////////////
  // Vector file
  ////////////////////////////////////////

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    int unsigned f_id, f_vl, f_sew, f_len, f_beats, f_last;
    fd = $fopen("testbench/store_vectors.txt", "r");
    if (fd == 0) begin
      tb_errors++;
      $display("ERROR: cannot open the store vector file");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Skip blank and comment lines
      if (line.len() == 0 || line[0] == "#") continue;
      n = $sscanf(line, "%h %h %h %h %h %h", f_id, f_vl, f_sew, f_len, f_beats, f_last);
      if (n != 6) continue;
      vec_id.push_back(insn_id_t'(f_id));
      vec_vl.push_back(vl_t'(f_vl));
      vec_vsew.push_back(vsew_t'(f_sew));
      vec_len.push_back(burst_len_t'(f_len));
      total_beats += f_beats;
      u_checker.add_expected(insn_id_t'(f_id), f_beats, f_last, f_len);
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////

  task automatic present_request(input int unsigned idx);
    pe_req_valid_i = 1'b1;
    pe_req_id_i    = vec_id[idx];
    pe_req_vl_i    = vec_vl[idx];
    pe_req_vsew_i  = vec_vsew[idx];
  endtask

  task automatic send_request(input int unsigned idx);
    int unsigned cnt;
    cnt = 0;
    present_request(idx);
    @(negedge clk_i);
    while (!pe_req_ready_o && cnt < WaitLimit) begin
      cnt++;
      @(negedge clk_i);
    end
    if (!pe_req_ready_o) begin
      timeouts++;
      $display("ERROR: timeout waiting for pe_req_ready_o on request %0d", idx);
    end
    @(posedge clk_i);
    #10;
    pe_req_valid_i = 1'b0;
  endtask

  // Request side must stay blocked for a while
  task automatic expect_ready_low(input int unsigned cycles, input logic check_idle);
    for (int unsigned i = 0; i < cycles; i++) begin
      @(negedge clk_i);
      if (pe_req_ready_o) begin
        tb_errors++;
        $display("ERROR: pe_req_ready_o high while the queue cannot accept");
      end
      if (check_idle && store_pending_o) begin
        tb_errors++;
        $display("ERROR: request with a running ID entered the queue");
      end
      @(posedge clk_i);
      #10;
    end
  endtask

  task automatic wait_for_pending(input logic value);
    int unsigned cnt;
    cnt = 0;
    @(negedge clk_i);
    while (store_pending_o != value && cnt < WaitLimit) begin
      cnt++;
      @(negedge clk_i);
    end
    if (store_pending_o != value) begin
      timeouts++;
      $display("ERROR: timeout waiting for store_pending_o to become %0d", value);
    end
    @(posedge clk_i);
    #10;
  endtask

  // One burst per instruction held until the packer acknowledges it
  task automatic addrgen_driver();
    int unsigned cnt;
    for (int unsigned i = 0; i < vec_len.size(); i++) begin
      addrgen_valid_i = 1'b1;
      addrgen_len_i   = vec_len[i];
      cnt = 0;
      @(negedge clk_i);
      while (!addrgen_ready_o && cnt < WaitLimit) begin
        cnt++;
        @(negedge clk_i);
      end
      if (!addrgen_ready_o) begin
        timeouts++;
        $display("ERROR: timeout waiting for addrgen_ready_o on burst %0d", i);
      end
      @(posedge clk_i);
      #10;
      addrgen_valid_i = 1'b0;
    end
  endtask

  // Lane operands, W ready stalls and B responses on every cycle
  task automatic cycle_driver();
    logic [NrLanes-1:0] taken;
    int unsigned        lane_sent [NrLanes];
    logic               keep;
    for (int l = 0; l < NrLanes; l++) lane_sent[l] = 0;
    while (!finished) begin
      @(negedge clk_i);
      taken = operand_valid_i & operand_ready_o;
      if (addrgen_ready_o) issued_cnt++;
      @(posedge clk_i);
      #10;
      for (int l = 0; l < NrLanes; l++) begin
        // An offer stays up until its lane takes it
        keep = operand_valid_i[l] && !taken[l];
        if (!keep) begin
          if (lane_sent[l] < total_beats && rand_bits(2) != '0) begin
            operand_i[l]       = rand_bits(64);
            operand_valid_i[l] = 1'b1;
            lane_sent[l]++;
          end else begin
            operand_valid_i[l] = 1'b0;
          end
        end
      end
      axi_w_ready_i = (rand_bits(2) != '0);
      axi_b_valid_i = 1'b0;
      if (!b_hold && issued_cnt > b_sent && rand_bits(1) != '0) begin
        axi_b_valid_i = 1'b1;
        b_sent++;
      end
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin : main_flow
    int unsigned idx;
    rst_ni             = 1'b0;
    pe_req_valid_i     = 1'b0;
    pe_req_id_i        = '0;
    pe_req_vl_i        = '0;
    pe_req_vsew_i      = '0;
    pe_vinsn_running_i = '1;
    operand_i          = '0;
    operand_valid_i    = '0;
    addrgen_valid_i    = 1'b0;
    addrgen_len_i      = '0;
    axi_w_ready_i      = 1'b0;
    axi_b_valid_i      = 1'b0;
    lfsr_q             = 16'd56243;
    tb_errors          = 0;
    timeouts           = 0;
    issued_cnt         = 0;
    b_sent             = 0;
    b_hold             = 1'b1;
    finished           = 1'b0;
    total_beats        = 0;
    load_vectors();
    repeat (16) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;

    if (vec_id.size() < 9) begin
      tb_errors++;
      $display("ERROR: vector file holds %0d instructions, 9 needed", vec_id.size());
    end else begin
      fork
        cycle_driver();
        addrgen_driver();
      join_none
      // Four in the queue and one parked while B is held off
      for (idx = 0; idx < 5; idx++) send_request(idx);
      present_request(5);
      expect_ready_low(StallCycles, 1'b0);
      b_hold = 1'b0;
      for (idx = 5; idx < 8; idx++) send_request(idx);
      wait_for_pending(1'b0);
      // Reused ID stays blocked until the sequencer retires it
      send_request(8);
      expect_ready_low(StallCycles, 1'b1);
      pe_vinsn_running_i = ~(insn_mask_t'(1) << vec_id[8]);
      wait_for_pending(1'b1);
      wait_for_pending(1'b0);
      repeat (4) @(posedge clk_i);
    end

    finished = 1'b1;
    if (beat_count != total_beats) begin
      tb_errors++;
      $display("ERROR: %0d W beats seen, %0d expected", beat_count, total_beats);
    end
    if (done_count != vec_id.size()) begin
      tb_errors++;
      $display("ERROR: %0d done bits seen, %0d expected", done_count, vec_id.size());
    end
    if (store_pending_o) begin
      tb_errors++;
      $display("ERROR: store_pending_o still high after the last commit");
    end
    $display("errors: checker %0d, testbench %0d, assertions %0d, timeouts %0d",
             checker_errors, tb_errors, UUT.u_asserts.fail_count, timeouts);
    if (checker_errors + tb_errors + UUT.u_asserts.fail_count + timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== testbench/store_vectors.txt ====
# Store vectors, one instruction per line, all fields in hex
# id vl vsew burst_len beats last_beat_bytes
0 10 3 03 04 20
1 0a 2 01 02 08
2 05 0 00 01 05
3 21 1 02 03 02
4 08 3 01 02 20
5 64 2 0c 0d 10
6 ff 3 3f 40 18
7 01 3 00 01 08
2 20 3 07 08 20

// ==== all.f ====
hdl/vstu_pkg.sv
hdl/store_issue_if.sv
hdl/lane_spill_reg.sv
hdl/store_insn_queue.sv
hdl/w_beat_packer.sv
hdl/vstu_top.sv
testbench/vstu_asserts.sv
testbench/vstu_checker.sv
testbench/tb_vstu.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_vstu -f all.f -o vsim

out=$(./obj_dir/vsim)
echo "$out"

if echo "$out" | grep -q "^sim passed$"; then
  exit 0
fi
exit 1
